//--- hdl/hb_defines.svh
`ifndef HB_DEFINES_SVH
`define HB_DEFINES_SVH

// bus population
`define HB_MASTER_NUM 2
`define HB_SLAVE_NUM 2

// master side and slave side address widths
`define HB_ADDR_WIDTH 16
`define HB_SLAVE_ADDR_WIDTH 12

// first address of slave 1, slave 0 sits below it
`define HB_ADDR_SPLIT 16'h1000

// wait slave latency, in cycles from first select to wait_finish
`define HB_WAIT_CYCLES 3

// slave depths in 32-bit words
`define HB_RAM_WORDS 256
`define HB_REG_WORDS 16

`endif

//--- hdl/hb_pkg.sv
`default_nettype none

`include "hb_defines.svh"

package hb_pkg;

  typedef logic [`HB_ADDR_WIDTH-1:0] hb_addr_t;
  typedef logic [`HB_SLAVE_ADDR_WIDTH-1:0] hb_slave_addr_t;
  typedef logic [31:0] hb_data_t;
  // 0 byte, 1 halfword, 2 word
  typedef logic [1:0] hb_width_t;
  typedef logic [3:0] hb_strb_t;
  typedef logic [`HB_SLAVE_NUM-1:0] hb_sel_t;
  typedef logic [`HB_MASTER_NUM-1:0] hb_grant_t;

  // lane enables for a write, data is already placed in its byte lanes
  function automatic hb_strb_t hb_byte_en(hb_width_t width, logic [1:0] offset);
    case (width)
      2'd0: hb_byte_en = hb_strb_t'(4'b0001 << offset);
      2'd1: hb_byte_en = offset[1] ? 4'b1100 : 4'b0011;
      default: hb_byte_en = 4'b1111;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- hdl/hb_bus_if.sv
`default_nettype none

`include "hb_defines.svh"

interface hb_bus_if
  import hb_pkg::*;
();

  // command side, driven by the controller only
  hb_slave_addr_t raddr;
  hb_slave_addr_t waddr;
  hb_data_t wdata;
  hb_width_t write_width;
  hb_sel_t ren;
  hb_sel_t wen;

  // return side, each slave drives its own element
  wire hb_data_t rdata [`HB_SLAVE_NUM];
  wire hb_sel_t wait_finish;

  modport controller (
    output raddr, waddr, wdata, write_width, ren, wen,
    input rdata, wait_finish
  );

  modport slave (
    input raddr, waddr, wdata, write_width, ren, wen,
    output rdata, wait_finish
  );

endinterface

`default_nettype wire

//--- hdl/bus_arbiter.sv
`default_nettype none

`include "hb_defines.svh"

module bus_arbiter
  import hb_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  input wire hb_grant_t req,
  input wire logic frame_done,
  output hb_grant_t accept,
  output logic busy
);

  hb_grant_t grant_q;
  hb_grant_t pick;

  // lowest index wins, master 0 is the core
  always_comb begin
    pick = '0;
    for (int i = `HB_MASTER_NUM - 1; i >= 0; i--) begin
      if (req[i]) begin
        pick = hb_grant_t'(1) << i;
      end
    end
  end

  // grant holds for the whole frame
  always_ff @(posedge clk) begin
    if (reset) begin
      grant_q <= '0;
    end else if (grant_q != '0) begin
      if (frame_done) begin
        grant_q <= '0;
      end
    end else begin
      grant_q <= pick;
    end
  end

  assign accept = grant_q;
  assign busy = |grant_q;

  // at most one master owns the bus
  a_grant_onehot : assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(accept)
  );

endmodule

`default_nettype wire

//--- hdl/address_decoder.sv
`default_nettype none

`include "hb_defines.svh"

module address_decoder
  import hb_pkg::*;
(
  input wire hb_addr_t addr,
  output hb_sel_t sel,
  output hb_slave_addr_t mapped_addr
);

  hb_addr_t base;
  hb_addr_t offset;

  // two regions, the split address belongs to slave 1
  always_comb begin
    if (addr < `HB_ADDR_SPLIT) begin
      sel = hb_sel_t'(1);
      base = '0;
    end else begin
      sel = hb_sel_t'(2);
      base = `HB_ADDR_SPLIT;
    end
  end

  assign offset = addr - base;

  // slave sees only its own window
  assign mapped_addr = offset[`HB_SLAVE_ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

//--- hdl/hb_controller.sv
`default_nettype none

`include "hb_defines.svh"

module hb_controller
  import hb_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  input wire hb_grant_t req,
  input wire hb_grant_t read,
  input wire hb_grant_t write,
  input wire hb_addr_t raddr [`HB_MASTER_NUM],
  input wire hb_addr_t waddr [`HB_MASTER_NUM],
  input wire hb_data_t wdata [`HB_MASTER_NUM],
  input wire hb_width_t write_width [`HB_MASTER_NUM],
  output hb_data_t master_rdata,
  output hb_grant_t master_accept,
  output logic stall_req,
  hb_bus_if.controller bus
);

  hb_grant_t grant;
  logic busy;
  logic frame_done;

  bus_arbiter u_arbiter (
    .clk(clk),
    .reset(reset),
    .req(req),
    .frame_done(frame_done),
    .accept(grant),
    .busy(busy)
  );

  assign master_accept = grant;

  // command of the granted master
  logic op_read;
  logic op_write;
  hb_addr_t raddr_mux;
  hb_addr_t waddr_mux;
  hb_data_t wdata_mux;
  hb_width_t width_mux;

  always_comb begin
    op_read = 1'b0;
    op_write = 1'b0;
    raddr_mux = '0;
    waddr_mux = '0;
    wdata_mux = '0;
    width_mux = '0;
    for (int i = 0; i < `HB_MASTER_NUM; i++) begin
      if (grant[i]) begin
        op_read = read[i];
        op_write = write[i];
        raddr_mux = raddr[i];
        waddr_mux = waddr[i];
        wdata_mux = wdata[i];
        width_mux = write_width[i];
      end
    end
  end

  hb_sel_t rsel;
  hb_sel_t wsel;
  hb_slave_addr_t raddr_rel;
  hb_slave_addr_t waddr_rel;

  address_decoder u_rdec (
    .addr(raddr_mux),
    .sel(rsel),
    .mapped_addr(raddr_rel)
  );

  address_decoder u_wdec (
    .addr(waddr_mux),
    .sel(wsel),
    .mapped_addr(waddr_rel)
  );

  // write wins when both are asserted
  logic hb_ren;
  logic hb_wen;
  hb_sel_t slave_rsel;
  hb_sel_t slave_wsel;

  assign hb_wen = busy && op_write;
  assign hb_ren = busy && op_read && !op_write;
  assign slave_rsel = hb_ren ? rsel : '0;
  assign slave_wsel = hb_wen ? wsel : '0;

  logic read_wait_finish;
  logic write_wait_finish;
  logic read_finish;
  logic read_stall;
  logic write_stall;
  logic arbiter_stall;

  assign read_wait_finish = |(bus.wait_finish & slave_rsel);
  assign write_wait_finish = |(bus.wait_finish & slave_wsel);
  assign write_stall = hb_wen && !write_wait_finish;
  // reads always spend one extra cycle for the registered data
  assign read_stall = hb_ren && !read_finish;
  assign arbiter_stall = |(req & ~grant);
  assign stall_req = arbiter_stall || write_stall || read_stall;

  always_comb begin
    if (hb_wen) begin
      frame_done = write_wait_finish;
    end else if (hb_ren) begin
      frame_done = read_finish;
    end else begin
      frame_done = busy;
    end
  end

  hb_sel_t rsel_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      read_finish <= 1'b0;
      rsel_last <= '0;
    end else begin
      rsel_last <= slave_rsel;
      if (frame_done) begin
        read_finish <= 1'b0;
      end else if (read_wait_finish) begin
        read_finish <= 1'b1;
      end
    end
  end

  assign bus.raddr = raddr_rel;
  assign bus.waddr = waddr_rel;
  assign bus.wdata = wdata_mux;
  assign bus.write_width = width_mux;
  assign bus.ren = read_stall ? slave_rsel : '0;
  assign bus.wen = slave_wsel;

  // data belongs to the slave read one cycle ago
  always_comb begin
    master_rdata = '0;
    for (int i = 0; i < `HB_SLAVE_NUM; i++) begin
      if (rsel_last[i]) begin
        master_rdata = bus.rdata[i];
      end
    end
  end

  a_ren_wen_excl : assert property (
    @(posedge clk) disable iff (reset)
    !((|bus.ren) && (|bus.wen))
  );

endmodule

`default_nettype wire

//--- hdl/hb_ram.sv
`default_nettype none

`include "hb_defines.svh"

module hb_ram
  import hb_pkg::*;
#(
  parameter int index = 0
) (
  input wire logic clk,
  input wire logic reset,
  hb_bus_if.slave bus
);

  localparam int ram_aw = $clog2(`HB_RAM_WORDS);

  hb_data_t mem [`HB_RAM_WORDS];
  hb_data_t rdata_q;
  hb_strb_t wstrb;
  logic [ram_aw-1:0] waddr_word;
  logic [ram_aw-1:0] raddr_word;

  // byte address to word index, upper window bits alias
  assign waddr_word = bus.waddr[ram_aw+1:2];
  assign raddr_word = bus.raddr[ram_aw+1:2];
  assign wstrb = hb_byte_en(bus.write_width, bus.waddr[1:0]);

  always_ff @(posedge clk) begin
    if (bus.wen[index]) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) begin
          mem[waddr_word][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rdata_q <= '0;
    end else if (bus.ren[index]) begin
      rdata_q <= mem[raddr_word];
    end
  end

  assign bus.rdata[index] = rdata_q;
  // zero wait, every access finishes in its first cycle
  assign bus.wait_finish[index] = 1'b1;

endmodule

`default_nettype wire

//--- hdl/hb_wait_slave.sv
`default_nettype none

`include "hb_defines.svh"

module hb_wait_slave
  import hb_pkg::*;
#(
  parameter int index = 1
) (
  input wire logic clk,
  input wire logic reset,
  hb_bus_if.slave bus
);

  localparam int reg_aw = $clog2(`HB_REG_WORDS);
  localparam int cnt_w = $clog2(`HB_WAIT_CYCLES + 1);

  hb_data_t regs [`HB_REG_WORDS];
  hb_data_t rdata_q;
  hb_strb_t wstrb;
  logic [cnt_w-1:0] cnt;
  logic finish_q;
  logic sel;

  assign sel = bus.ren[index] || bus.wen[index];
  assign wstrb = hb_byte_en(bus.write_width, bus.waddr[1:0]);

  // finish pulses for one cycle, then the controller drops the select
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
      finish_q <= 1'b0;
    end else if (sel && !finish_q) begin
      if (cnt == cnt_w'(`HB_WAIT_CYCLES - 1)) begin
        cnt <= '0;
        finish_q <= 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end else begin
      finish_q <= 1'b0;
    end
  end

  // commit on the edge that raises wait_finish
  always_ff @(posedge clk) begin
    if (sel && !finish_q && cnt == cnt_w'(`HB_WAIT_CYCLES - 1)) begin
      if (bus.wen[index]) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b]) begin
            regs[bus.waddr[reg_aw+1:2]][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= regs[bus.raddr[reg_aw+1:2]];
      end
    end
  end

  assign bus.rdata[index] = rdata_q;
  assign bus.wait_finish[index] = finish_q;

  // controller must hold the access while this slave counts
  a_sel_stable : assert property (
    @(posedge clk) disable iff (reset)
    (cnt != '0) |-> $stable({bus.ren[index], bus.wen[index]})
  );

endmodule

`default_nettype wire

//--- hdl/hb_subsystem.sv
`default_nettype none

`include "hb_defines.svh"

module hb_subsystem
  import hb_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  // master 0, the core
  input wire logic m0_req,
  input wire logic m0_read,
  input wire logic m0_write,
  input wire hb_addr_t m0_raddr,
  input wire hb_addr_t m0_waddr,
  input wire hb_data_t m0_wdata,
  input wire hb_width_t m0_write_width,
  // master 1
  input wire logic m1_req,
  input wire logic m1_read,
  input wire logic m1_write,
  input wire hb_addr_t m1_raddr,
  input wire hb_addr_t m1_waddr,
  input wire hb_data_t m1_wdata,
  input wire hb_width_t m1_write_width,
  output hb_data_t master_rdata,
  output hb_grant_t master_accept,
  output logic stall_req
);

  hb_addr_t raddr [`HB_MASTER_NUM];
  hb_addr_t waddr [`HB_MASTER_NUM];
  hb_data_t wdata [`HB_MASTER_NUM];
  hb_width_t write_width [`HB_MASTER_NUM];

  assign raddr[0] = m0_raddr;
  assign raddr[1] = m1_raddr;
  assign waddr[0] = m0_waddr;
  assign waddr[1] = m1_waddr;
  assign wdata[0] = m0_wdata;
  assign wdata[1] = m1_wdata;
  assign write_width[0] = m0_write_width;
  assign write_width[1] = m1_write_width;

  hb_bus_if bus ();

  hb_controller u_controller (
    .clk(clk),
    .reset(reset),
    .req({m1_req, m0_req}),
    .read({m1_read, m0_read}),
    .write({m1_write, m0_write}),
    .raddr(raddr),
    .waddr(waddr),
    .wdata(wdata),
    .write_width(write_width),
    .master_rdata(master_rdata),
    .master_accept(master_accept),
    .stall_req(stall_req),
    .bus(bus)
  );

  hb_ram #(
    .index(0)
  ) u_ram (
    .clk(clk),
    .reset(reset),
    .bus(bus)
  );

  hb_wait_slave #(
    .index(1)
  ) u_wait_slave (
    .clk(clk),
    .reset(reset),
    .bus(bus)
  );

endmodule

`default_nettype wire

//--- verif/hb_tb.sv
`default_nettype none

`include "hb_defines.svh"

module hb_tb
  import hb_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_transfers = 284;
  localparam int timeout_cycles = num_transfers * (`HB_WAIT_CYCLES + 4) + 200;
  localparam int ram_aw = $clog2(`HB_RAM_WORDS);
  localparam int reg_aw = $clog2(`HB_REG_WORDS);
  localparam int rnd_per_master = 100;
  // moves an address to the other slave and another word
  localparam logic [15:0] other_addr_flip = 16'h103c;

  typedef struct packed {
    logic is_write;
    logic [15:0] addr;
    hb_data_t data;
    hb_width_t width;
    hb_data_t rdata;
  } done_t;

  logic clk;
  logic reset;
  logic req_d [`HB_MASTER_NUM];
  logic read_d [`HB_MASTER_NUM];
  logic write_d [`HB_MASTER_NUM];
  logic [15:0] raddr_d [`HB_MASTER_NUM];
  logic [15:0] waddr_d [`HB_MASTER_NUM];
  hb_data_t wdata_d [`HB_MASTER_NUM];
  hb_width_t width_d [`HB_MASTER_NUM];
  hb_data_t master_rdata;
  hb_grant_t master_accept;
  logic stall_req;
  logic write_also_reads;

  // results of each master's last transfer
  int stall_count [`HB_MASTER_NUM];
  int first_cyc [`HB_MASTER_NUM];
  int last_cyc [`HB_MASTER_NUM];
  logic done_stall [`HB_MASTER_NUM];
  logic wait_stalled [`HB_MASTER_NUM];

  done_t done_q [$];
  hb_data_t ram_ref [`HB_RAM_WORDS];
  hb_data_t reg_ref [`HB_REG_WORDS];
  logic cmd_write [2*rnd_per_master];
  logic [15:0] cmd_addr [2*rnd_per_master];
  hb_data_t cmd_data [2*rnd_per_master];
  hb_width_t cmd_width [2*rnd_per_master];
  int cycles;
  int checks;
  int errors;
  int test_err_start;

  hb_subsystem dut (
    .clk(clk),
    .reset(reset),
    .m0_req(req_d[0]),
    .m0_read(read_d[0]),
    .m0_write(write_d[0]),
    .m0_raddr(raddr_d[0]),
    .m0_waddr(waddr_d[0]),
    .m0_wdata(wdata_d[0]),
    .m0_write_width(width_d[0]),
    .m1_req(req_d[1]),
    .m1_read(read_d[1]),
    .m1_write(write_d[1]),
    .m1_raddr(raddr_d[1]),
    .m1_waddr(waddr_d[1]),
    .m1_wdata(wdata_d[1]),
    .m1_write_width(width_d[1]),
    .master_rdata(master_rdata),
    .master_accept(master_accept),
    .stall_req(stall_req)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // lane mask from width and byte offset
  function automatic hb_data_t merge_lanes(hb_data_t old, hb_data_t data, hb_width_t width,
                                           logic [1:0] offset);
    hb_data_t mask;
    case (width)
      2'd0: mask = 32'h0000_00ff << {offset, 3'b000};
      2'd1: mask = offset[1] ? 32'hffff_0000 : 32'h0000_ffff;
      default: mask = 32'hffff_ffff;
    endcase
    return (old & ~mask) | (data & mask);
  endfunction

  // applies one access to the model, returns the word now stored there
  function automatic hb_data_t ref_access(logic is_write, logic [15:0] addr, hb_data_t data,
                                          hb_width_t width);
    logic [15:0] rel;
    if (addr < `HB_ADDR_SPLIT) begin
      rel = addr;
      if (is_write) begin
        ram_ref[rel[ram_aw+1:2]] = merge_lanes(ram_ref[rel[ram_aw+1:2]], data, width, rel[1:0]);
      end
      return ram_ref[rel[ram_aw+1:2]];
    end
    rel = addr - `HB_ADDR_SPLIT;
    if (is_write) begin
      reg_ref[rel[reg_aw+1:2]] = merge_lanes(reg_ref[rel[reg_aw+1:2]], data, width, rel[1:0]);
    end
    return reg_ref[rel[reg_aw+1:2]];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("error at %0t: %s", $time, what);
    end
  endtask

  // one frame, done once accept falls again after the grant
  task automatic transfer(input int m, input logic is_write, input logic [15:0] addr,
                          input hb_data_t data, input hb_width_t width);
    done_t rec;
    logic seen;
    logic finished;
    seen = 1'b0;
    finished = 1'b0;
    stall_count[m] = 0;
    wait_stalled[m] = 1'b1;
    rec = '0;
    @(negedge clk);
    req_d[m] = 1'b1;
    read_d[m] = !is_write || write_also_reads;
    write_d[m] = is_write;
    // the address of the unused direction points elsewhere
    raddr_d[m] = is_write ? addr ^ other_addr_flip : addr;
    waddr_d[m] = is_write ? addr : addr ^ other_addr_flip;
    wdata_d[m] = data;
    width_d[m] = width;
    while (!finished) begin
      @(negedge clk);
      if (master_accept[m]) begin
        if (!seen) begin
          first_cyc[m] = cycles;
        end
        seen = 1'b1;
        last_cyc[m] = cycles;
        rec.rdata = master_rdata;
        done_stall[m] = stall_req;
      end else if (seen) begin
        finished = 1'b1;
      end else if (!stall_req) begin
        wait_stalled[m] = 1'b0;
      end
      if (stall_req && !finished) begin
        stall_count[m]++;
      end
    end
    // released in the idle cycle, before the arbiter looks again
    req_d[m] = 1'b0;
    read_d[m] = 1'b0;
    write_d[m] = 1'b0;
    rec.is_write = is_write;
    rec.addr = addr;
    rec.data = data;
    rec.width = width;
    done_q.push_back(rec);
  endtask

  task automatic run_random(input int m);
    int idx;
    for (int k = 0; k < rnd_per_master; k++) begin
      idx = m * rnd_per_master + k;
      transfer(m, cmd_write[idx], cmd_addr[idx], cmd_data[idx], cmd_width[idx]);
    end
  endtask

  task automatic check_contention();
    check_true(last_cyc[0] < first_cyc[1], "master 1 was granted before master 0 finished");
    check_true(first_cyc[1] >= last_cyc[0] + 2, "no idle cycle between the two grants");
    check_true(wait_stalled[1], "stall_req went low while master 1 waited for its grant");
  endtask

  task automatic finish_test(input int num, input string name);
    while (done_q.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
    if (errors == test_err_start) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - test_err_start);
    end
    test_err_start = errors;
  endtask

  // reads are checked in completion order
  initial begin : compare_completions
    done_t rec;
    hb_data_t expected;
    forever begin
      @(negedge clk);
      while (done_q.size() != 0) begin
        rec = done_q.pop_front();
        expected = ref_access(rec.is_write, rec.addr, rec.data, rec.width);
        if (!rec.is_write) begin
          check_value("master_rdata", rec.rdata, expected);
        end
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a transfer never completed", cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int ram_wr_stalls;
    int ram_rd_stalls;
    hb_data_t d0;
    hb_data_t d1;
    void'($urandom(32'h34457f1e));
    checks = 0;
    errors = 0;
    test_err_start = 0;
    write_also_reads = 1'b0;
    for (int m = 0; m < `HB_MASTER_NUM; m++) begin
      req_d[m] = 1'b0;
      read_d[m] = 1'b0;
      write_d[m] = 1'b0;
      raddr_d[m] = '0;
      waddr_d[m] = '0;
      wdata_d[m] = '0;
      width_d[m] = '0;
    end
    reset = 1'b1;
    repeat (5) @(negedge clk);
    reset = 1'b0;

    repeat (3) begin
      @(negedge clk);
      check_value("master_accept", 32'(master_accept), 32'd0);
      check_value("stall_req", 32'(stall_req), 32'd0);
    end
    finish_test(1, "reset state");

    // also fills the RAM words used later
    for (int i = 0; i < 16; i++) begin
      transfer(0, 1'b1, 16'(i * 4), $urandom, 2'd2);
      ram_wr_stalls = stall_count[0];
    end
    for (int i = 0; i < 16; i++) begin
      transfer(0, 1'b0, 16'(i * 4), '0, 2'd2);
      check_true(stall_count[0] >= 1, "RAM read completed without a stall");
      check_true(!done_stall[0], "stall_req high in the RAM read completion cycle");
      ram_rd_stalls = stall_count[0];
    end
    finish_test(2, "RAM word access");

    for (int off = 0; off < 4; off++) begin
      transfer(0, 1'b1, 16'h0010 + 16'(off), $urandom, 2'd0);
      transfer(0, 1'b0, 16'h0010, '0, 2'd2);
      transfer(0, 1'b1, 16'h0020 + 16'(off), $urandom, 2'd1);
      transfer(0, 1'b0, 16'h0020, '0, 2'd2);
    end
    finish_test(3, "byte and halfword merge");

    for (int i = 0; i < `HB_REG_WORDS; i++) begin
      transfer(0, 1'b1, `HB_ADDR_SPLIT + 16'(i * 4), $urandom, 2'd2);
      check_true(stall_count[0] >= ram_wr_stalls + `HB_WAIT_CYCLES,
                 "wait slave write stalled too briefly");
    end
    for (int i = 0; i < `HB_REG_WORDS; i++) begin
      transfer(0, 1'b0, `HB_ADDR_SPLIT + 16'(i * 4), '0, 2'd2);
      check_true(stall_count[0] >= ram_rd_stalls + `HB_WAIT_CYCLES,
                 "wait slave read stalled too briefly");
    end
    finish_test(4, "wait slave access");

    d0 = $urandom;
    d1 = $urandom;
    fork
      transfer(0, 1'b1, 16'h0030, d0, 2'd2);
      transfer(1, 1'b1, `HB_ADDR_SPLIT + 16'h0008, d1, 2'd2);
    join
    check_contention();
    fork
      transfer(0, 1'b0, `HB_ADDR_SPLIT + 16'h0008, '0, 2'd2);
      transfer(1, 1'b0, 16'h0030, '0, 2'd2);
    join
    check_contention();
    finish_test(5, "arbitration");

    for (int i = 0; i < 2 * rnd_per_master; i++) begin
      cmd_write[i] = ($urandom_range(0, 1) == 1);
      cmd_addr[i] = 16'($urandom_range(0, 63));
      if ($urandom_range(0, 1) == 1) begin
        cmd_addr[i] = cmd_addr[i] + `HB_ADDR_SPLIT;
      end
      cmd_data[i] = $urandom;
      cmd_width[i] = hb_width_t'($urandom_range(0, 2));
    end
    // write frames raise read as well, the write has to win
    write_also_reads = 1'b1;
    fork
      run_random(0);
      run_random(1);
    join
    finish_test(6, "random mix");

    $display("tests done, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/hb_pkg.sv
hdl/hb_bus_if.sv
hdl/bus_arbiter.sv
hdl/address_decoder.sv
hdl/hb_controller.sv
hdl/hb_ram.sv
hdl/hb_wait_slave.sv
hdl/hb_subsystem.sv
verif/hb_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = hb_tb
FILELIST = list.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)
